// File: verilog/ip_rx_pkg.sv
// IPv4 receive package
// byte type, decoded header fields, frame control states and the
// protocol constants used by the parser and frame control
`default_nettype none

package ip_rx_pkg;

    typedef logic [7:0] byte_t;

    // header fields that leave the block, in wire order
    typedef struct packed {
        logic [15:0] length;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [15:0] checksum;
        logic [31:0] source_ip;
        logic [31:0] dest_ip;
    } ip_hdr_t;

    // frame control states
    typedef enum logic [2:0] {
        read_header,
        read_payload,
        read_payload_last,
        wait_last,
        hdr_hold
    } rx_state_t;

    // fixed header without options
    //  0 version/ihl    1 dscp/ecn      2-3 total length
    //  4-5 ident        6-7 flags/frag  8 ttl   9 protocol
    //  10-11 checksum   12-15 source    16-19 destination
    localparam int          IP_HDR_BYTES      = 20;
    localparam logic [3:0]  IP_VERSION_V4     = 4'd4;
    localparam logic [3:0]  IP_IHL_NO_OPTIONS = 4'd5;

    // one's-complement sum over a good header folds to all ones
    localparam logic [15:0] CSUM_GOOD         = 16'hffff;

    // pointer wide enough to count 20 header bytes
    localparam int          HDR_PTR_W         = 5;

endpackage

`default_nettype wire

// File: verilog/ip_stream_if.sv
// IPv4 receive byte stream
// one byte per beat with valid/ready handshake, end of frame and error flag
`timescale 1ns/1ps
`default_nettype none

interface ip_stream_if;
    import ip_rx_pkg::*;

    byte_t tdata;
    logic  tvalid;
    logic  tready;
    logic  tlast;
    logic  tuser;

    modport source (
        output tdata, tvalid, tlast, tuser,
        input  tready
    );

    modport sink (
        input  tdata, tvalid, tlast, tuser,
        output tready
    );

endinterface

`default_nettype wire

// File: verilog/ip_hdr_if.sv
// IPv4 header parser link
// frame control tells the parser which bytes belong to the header,
// the parser returns the decoded fields and the header checks
`timescale 1ns/1ps
`default_nettype none

interface ip_hdr_if;
    import ip_rx_pkg::*;

    // from frame control
    logic    beat;
    logic    abort;

    // from the parser, checks valid with done
    ip_hdr_t fields;
    logic    done;
    logic    version_ok;
    logic    checksum_ok;

    modport parser (
        input  beat, abort,
        output fields, done, version_ok, checksum_ok
    );

    modport ctrl (
        output beat, abort,
        input  fields, done, version_ok, checksum_ok
    );

endinterface

`default_nettype wire

// File: verilog/ip_hdr_parser.sv
// IPv4 header parser
// collects the 20 header bytes into fields, keeps the running
// one's-complement header sum and checks version, IHL and checksum
`timescale 1ns/1ps
`default_nettype none

module ip_hdr_parser (
    input  logic             clk,
    input  logic             rst_n,
    input  ip_rx_pkg::byte_t tdata,
    ip_hdr_if.parser         hdr
);
    import ip_rx_pkg::*;

    logic [HDR_PTR_W-1:0] ptr_q;
    logic [15:0]          sum_q;
    logic [15:0]          sum_next;
    logic                 last_byte;
    byte_t                vihl_q;
    ip_hdr_t              fields_q;

    // 16 bit add with end-around carry
    function automatic logic [15:0] add_1c(input logic [15:0] a, input logic [15:0] b);
        logic [16:0] t;
        t = {1'b0, a} + {1'b0, b};
        return t[15:0] + {15'd0, t[16]};
    endfunction

    assign last_byte = (ptr_q == HDR_PTR_W'(IP_HDR_BYTES - 1));

    // even bytes are the high half of a word
    assign sum_next = ptr_q[0] ? add_1c(sum_q, {8'h00, tdata})
                               : add_1c(sum_q, {tdata, 8'h00});

    assign hdr.done        = hdr.beat && last_byte;
    assign hdr.version_ok  = (vihl_q == {IP_VERSION_V4, IP_IHL_NO_OPTIONS});
    assign hdr.checksum_ok = (sum_next == CSUM_GOOD);

    // last destination byte bypasses the register so done sees a full header
    always_comb begin
        hdr.fields = fields_q;
        if (last_byte) begin
            hdr.fields.dest_ip[7:0] = tdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr_q <= '0;
            sum_q <= '0;
        end else if (hdr.abort || hdr.done) begin
            ptr_q <= '0;
            sum_q <= '0;
        end else if (hdr.beat) begin
            ptr_q <= ptr_q + 1'b1;
            sum_q <= sum_next;
        end
    end

    // field capture by byte position
    always_ff @(posedge clk) begin
        if (hdr.beat) begin
            case (int'(ptr_q))
                0:  vihl_q                     <= tdata;
                2:  fields_q.length[15:8]      <= tdata;
                3:  fields_q.length[7:0]       <= tdata;
                8:  fields_q.ttl               <= tdata;
                9:  fields_q.protocol          <= tdata;
                10: fields_q.checksum[15:8]    <= tdata;
                11: fields_q.checksum[7:0]     <= tdata;
                12: fields_q.source_ip[31:24]  <= tdata;
                13: fields_q.source_ip[23:16]  <= tdata;
                14: fields_q.source_ip[15:8]   <= tdata;
                15: fields_q.source_ip[7:0]    <= tdata;
                16: fields_q.dest_ip[31:24]    <= tdata;
                17: fields_q.dest_ip[23:16]    <= tdata;
                18: fields_q.dest_ip[15:8]     <= tdata;
                19: fields_q.dest_ip[7:0]      <= tdata;
                // dscp/ecn, ident, flags and offset only feed the sum
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/ip_frame_ctrl.sv
// IPv4 frame control
// runs the receive FSM, validates the parsed header, presents the
// header beat, counts and trims the payload and raises error pulses
`timescale 1ns/1ps
`default_nettype none

module ip_frame_ctrl (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               s_tvalid,
    input  logic               s_tlast,
    input  logic               s_tuser,
    input  ip_rx_pkg::byte_t   s_tdata,
    output logic               s_tready,
    ip_hdr_if.ctrl             hdr,
    input  logic               m_hdr_ready,
    output logic               m_hdr_valid,
    output ip_rx_pkg::ip_hdr_t m_fields,
    ip_stream_if.source        pay,
    output logic               err_header_early,
    output logic               err_payload_early,
    output logic               err_bad_header,
    output logic               err_bad_checksum
);
    import ip_rx_pkg::*;

    rx_state_t   state_q;
    rx_state_t   state_d;
    logic        s_tready_d;
    logic        m_hdr_valid_d;
    logic [15:0] count_q;
    logic [15:0] count_d;
    byte_t       last_q;
    logic        in_beat;
    logic        length_ok;
    logic        load_fields;
    logic        store_last;
    logic        frame_end;
    logic        err_header_early_d;
    logic        err_payload_early_d;
    logic        err_bad_header_d;
    logic        err_bad_checksum_d;

    assign in_beat   = s_tready && s_tvalid;
    assign hdr.beat  = (state_q == read_header) && in_beat;
    assign hdr.abort = hdr.beat && s_tlast;
    assign length_ok = (hdr.fields.length >= 16'(IP_HDR_BYTES));

    always_comb begin
        state_d             = state_q;
        s_tready_d          = 1'b0;
        m_hdr_valid_d       = m_hdr_valid && !m_hdr_ready;
        count_d             = count_q;
        load_fields         = 1'b0;
        store_last          = 1'b0;
        frame_end           = 1'b0;
        err_header_early_d  = 1'b0;
        err_payload_early_d = 1'b0;
        err_bad_header_d    = 1'b0;
        err_bad_checksum_d  = 1'b0;

        pay.tdata  = s_tdata;
        pay.tvalid = 1'b0;
        pay.tlast  = s_tlast;
        pay.tuser  = s_tuser;

        case (state_q)
            read_header: begin
                s_tready_d = 1'b1;
                count_d    = hdr.fields.length - 16'(IP_HDR_BYTES);
                if (hdr.done) begin
                    if (!hdr.version_ok || !length_ok) begin
                        err_bad_header_d = 1'b1;
                        state_d          = wait_last;
                    end else if (!hdr.checksum_ok) begin
                        err_bad_checksum_d = 1'b1;
                        state_d            = wait_last;
                    end else if (s_tlast && count_d != 16'd0) begin
                        // no payload byte left to carry tuser
                        err_header_early_d = 1'b1;
                    end else begin
                        m_hdr_valid_d = 1'b1;
                        load_fields   = 1'b1;
                        if (count_d == 16'd0) begin
                            // header only, anything after it is pad
                            s_tready_d = 1'b1;
                            state_d    = wait_last;
                        end else begin
                            s_tready_d = pay.tready;
                            state_d    = read_payload;
                        end
                    end
                    frame_end = s_tlast;
                end else if (hdr.beat && s_tlast) begin
                    err_header_early_d = 1'b1;
                    frame_end          = 1'b1;
                end
            end
            read_payload: begin
                s_tready_d = pay.tready;
                if (in_beat) begin
                    count_d    = count_q - 16'd1;
                    pay.tvalid = 1'b1;
                    if (s_tlast) begin
                        if (count_q > 16'd1) begin
                            pay.tuser           = 1'b1;
                            err_payload_early_d = 1'b1;
                        end
                        frame_end = 1'b1;
                    end else if (count_q == 16'd1) begin
                        // hold the final byte until the frame ends
                        store_last = 1'b1;
                        pay.tvalid = 1'b0;
                        state_d    = read_payload_last;
                    end
                end
            end
            read_payload_last: begin
                s_tready_d = pay.tready;
                pay.tdata  = last_q;
                if (in_beat && s_tlast) begin
                    pay.tvalid = 1'b1;
                    frame_end  = 1'b1;
                end
            end
            wait_last: begin
                s_tready_d = 1'b1;
                frame_end  = in_beat && s_tlast;
            end
            hdr_hold: begin
                frame_end = 1'b1;
            end
            default: state_d = read_header;
        endcase

        // next header waits until the current header beat is taken
        if (frame_end) begin
            s_tready_d = !m_hdr_valid_d;
            state_d    = m_hdr_valid_d ? hdr_hold : read_header;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q           <= read_header;
            s_tready          <= 1'b0;
            m_hdr_valid       <= 1'b0;
            count_q           <= '0;
            err_header_early  <= 1'b0;
            err_payload_early <= 1'b0;
            err_bad_header    <= 1'b0;
            err_bad_checksum  <= 1'b0;
        end else begin
            state_q           <= state_d;
            s_tready          <= s_tready_d;
            m_hdr_valid       <= m_hdr_valid_d;
            count_q           <= count_d;
            err_header_early  <= err_header_early_d;
            err_payload_early <= err_payload_early_d;
            err_bad_header    <= err_bad_header_d;
            err_bad_checksum  <= err_bad_checksum_d;
        end
    end

    always_ff @(posedge clk) begin
        if (load_fields) begin
            m_fields <= hdr.fields;
        end
        if (store_last) begin
            last_q <= s_tdata;
        end
    end

endmodule

`default_nettype wire

// File: verilog/ip_payload_skid.sv
// IPv4 payload output buffer
// two-entry registered buffer with early ready, keeps the output
// registered while absorbing one extra beat under back-pressure
`timescale 1ns/1ps
`default_nettype none

module ip_payload_skid (
    input  logic             clk,
    input  logic             rst_n,
    ip_stream_if.sink        in,
    output ip_rx_pkg::byte_t m_tdata,
    output logic             m_tvalid,
    output logic             m_tlast,
    output logic             m_tuser,
    input  logic             m_tready
);
    import ip_rx_pkg::*;

    logic  in_ready_q;
    logic  out_valid_d;
    byte_t tmp_data_q;
    logic  tmp_valid_q;
    logic  tmp_valid_d;
    logic  tmp_last_q;
    logic  tmp_user_q;
    logic  in_to_out;
    logic  in_to_tmp;
    logic  tmp_to_out;

    // source may send next cycle if downstream takes data or both entries are free
    assign in.tready = m_tready || (!tmp_valid_q && !m_tvalid);

    always_comb begin
        out_valid_d = m_tvalid;
        tmp_valid_d = tmp_valid_q;
        in_to_out   = 1'b0;
        in_to_tmp   = 1'b0;
        tmp_to_out  = 1'b0;

        if (in_ready_q) begin
            if (m_tready || !m_tvalid) begin
                out_valid_d = in.tvalid;
                in_to_out   = 1'b1;
            end else begin
                // output stalled, park the beat
                tmp_valid_d = in.tvalid;
                in_to_tmp   = 1'b1;
            end
        end else if (m_tready) begin
            out_valid_d = tmp_valid_q;
            tmp_valid_d = 1'b0;
            tmp_to_out  = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_ready_q  <= 1'b0;
            m_tvalid    <= 1'b0;
            tmp_valid_q <= 1'b0;
        end else begin
            in_ready_q  <= in.tready;
            m_tvalid    <= out_valid_d;
            tmp_valid_q <= tmp_valid_d;
        end
    end

    always_ff @(posedge clk) begin
        if (in_to_out) begin
            m_tdata <= in.tdata;
            m_tlast <= in.tlast;
            m_tuser <= in.tuser;
        end else if (tmp_to_out) begin
            m_tdata <= tmp_data_q;
            m_tlast <= tmp_last_q;
            m_tuser <= tmp_user_q;
        end
        if (in_to_tmp) begin
            tmp_data_q <= in.tdata;
            tmp_last_q <= in.tlast;
            tmp_user_q <= in.tuser;
        end
    end

endmodule

`default_nettype wire

// File: verilog/ip_rx_top.sv
// IPv4 receive block
// strips and checks the 20-byte IPv4 header of a byte stream, presents
// the header fields and forwards the payload trimmed to the IP length
`timescale 1ns/1ps
`default_nettype none

module ip_rx_top (
    input  logic             clk,
    input  logic             rst_n,
    // input stream
    input  ip_rx_pkg::byte_t s_tdata,
    input  logic             s_tvalid,
    output logic             s_tready,
    input  logic             s_tlast,
    input  logic             s_tuser,
    // header output
    output logic             m_hdr_valid,
    input  logic             m_hdr_ready,
    output logic [15:0]      m_ip_length,
    output logic [7:0]       m_ip_ttl,
    output logic [7:0]       m_ip_protocol,
    output logic [15:0]      m_ip_checksum,
    output logic [31:0]      m_ip_source_ip,
    output logic [31:0]      m_ip_dest_ip,
    // payload output
    output ip_rx_pkg::byte_t m_tdata,
    output logic             m_tvalid,
    input  logic             m_tready,
    output logic             m_tlast,
    output logic             m_tuser,
    // error pulses
    output logic             err_header_early,
    output logic             err_payload_early,
    output logic             err_bad_header,
    output logic             err_bad_checksum
);
    import ip_rx_pkg::*;

    ip_hdr_t m_fields;

    ip_hdr_if    hdr_bus ();
    ip_stream_if pay_bus ();

    ip_hdr_parser u_parser (
        .clk   (clk),
        .rst_n (rst_n),
        .tdata (s_tdata),
        .hdr   (hdr_bus.parser)
    );

    ip_frame_ctrl u_ctrl (
        .clk               (clk),
        .rst_n             (rst_n),
        .s_tvalid          (s_tvalid),
        .s_tlast           (s_tlast),
        .s_tuser           (s_tuser),
        .s_tdata           (s_tdata),
        .s_tready          (s_tready),
        .hdr               (hdr_bus.ctrl),
        .m_hdr_ready       (m_hdr_ready),
        .m_hdr_valid       (m_hdr_valid),
        .m_fields          (m_fields),
        .pay               (pay_bus.source),
        .err_header_early  (err_header_early),
        .err_payload_early (err_payload_early),
        .err_bad_header    (err_bad_header),
        .err_bad_checksum  (err_bad_checksum)
    );

    ip_payload_skid u_skid (
        .clk      (clk),
        .rst_n    (rst_n),
        .in       (pay_bus.sink),
        .m_tdata  (m_tdata),
        .m_tvalid (m_tvalid),
        .m_tlast  (m_tlast),
        .m_tuser  (m_tuser),
        .m_tready (m_tready)
    );

    // header fields out as separate ports
    assign m_ip_length    = m_fields.length;
    assign m_ip_ttl       = m_fields.ttl;
    assign m_ip_protocol  = m_fields.protocol;
    assign m_ip_checksum  = m_fields.checksum;
    assign m_ip_source_ip = m_fields.source_ip;
    assign m_ip_dest_ip   = m_fields.dest_ip;

endmodule

`default_nettype wire

// File: tests/ip_frame_model.svh
// IPv4 receive reference model
// builds random frames from the LFSR and queues the header beats,
// output beats and error pulses the receive block should produce
`ifndef IP_FRAME_MODEL_SVH
`define IP_FRAME_MODEL_SVH

localparam int KIND_GOOD      = 0;
localparam int KIND_PADDED    = 1;
localparam int KIND_TRUNC     = 2;
localparam int KIND_BAD_CSUM  = 3;
localparam int KIND_BAD_HDR   = 4;
localparam int KIND_HDR_EARLY = 5;
localparam int HDR_BYTES      = 20;

// input beats as {tlast, data}, output beats as {tlast, tuser, data}
logic [8:0] frame_q[$];
ip_hdr_t    exp_hdr_q[$];
logic [9:0] exp_out_q[$];
// header early, payload early, bad header, bad checksum
int         exp_err[4];
int         bytes_total;

// one's-complement sum of the ten header words, checksum word as zero
function automatic logic [15:0] header_checksum(input byte_t h[20]);
    logic [31:0] sum;
    int          w;
    sum = 32'd0;
    for (w = 0; w < 10; w++) begin
        if (w != 5) begin
            sum = sum + {16'd0, h[2*w], h[2*w+1]};
        end
    end
    while (sum[31:16] != 16'd0) begin
        sum = {16'd0, sum[15:0]} + {16'd0, sum[31:16]};
    end
    return ~sum[15:0];
endfunction

task automatic build_frame(input int kind);
    byte_t       h[20];
    byte_t       all[$];
    ip_hdr_t     f;
    logic [15:0] mask;
    logic [3:0]  nib;
    byte_t       b;
    int          pay_len;
    int          pad_len;
    int          cut;
    int          n;
    int          i;

    pay_len = lfsr_bits(6) % 41;
    pad_len = (kind == KIND_GOOD) ? 0 : lfsr_bits(3) % 7;
    if (kind == KIND_PADDED && pad_len == 0) begin
        pad_len = 1;
    end
    if (kind == KIND_TRUNC && pay_len < 2) begin
        pay_len = 2;
    end
    cut = pay_len;
    if (kind == KIND_TRUNC) begin
        // at least one payload byte arrives, at least one is missing
        cut = 1 + lfsr_bits(6) % (pay_len - 1);
    end

    f.length    = 16'(HDR_BYTES + pay_len);
    f.ttl       = 8'(lfsr_bits(8));
    f.protocol  = 8'(lfsr_bits(8));
    f.source_ip = lfsr_bits(32);
    f.dest_ip   = lfsr_bits(32);
    h[0] = 8'h45;
    // dscp/ecn, ident, flags and offset are random filler
    for (i = 1; i < 8; i++) begin
        h[i] = 8'(lfsr_bits(8));
    end
    h[2]  = f.length[15:8];
    h[3]  = f.length[7:0];
    h[8]  = f.ttl;
    h[9]  = f.protocol;
    h[10] = 8'h00;
    h[11] = 8'h00;
    for (i = 0; i < 4; i++) begin
        h[12 + i] = f.source_ip[31 - 8*i -: 8];
        h[16 + i] = f.dest_ip[31 - 8*i -: 8];
    end
    f.checksum = header_checksum(h);
    h[10] = f.checksum[15:8];
    h[11] = f.checksum[7:0];

    if (kind == KIND_BAD_CSUM) begin
        // top bit clear so 0000 and ffff never swap into a valid sum
        mask  = {1'b0, 15'(lfsr_bits(15))} | 16'h0001;
        h[10] = h[10] ^ mask[15:8];
        h[11] = h[11] ^ mask[7:0];
    end
    if (kind == KIND_BAD_HDR) begin
        // checksum is left stale, so the header error must win
        nib = 4'(lfsr_bits(4));
        if (lfsr_bits(1) != 0) begin
            h[0][7:4] = (nib == 4'd4) ? 4'd6 : nib;
        end else begin
            h[0][3:0] = (nib == 4'd5) ? 4'd6 : nib;
        end
    end

    for (i = 0; i < HDR_BYTES; i++) begin
        all.push_back(h[i]);
    end
    for (i = 0; i < pay_len; i++) begin
        b = 8'(lfsr_bits(8));
        all.push_back(b);
        if (kind <= KIND_TRUNC && i < cut) begin
            exp_out_q.push_back({i == cut - 1, kind == KIND_TRUNC && i == cut - 1, b});
        end
    end
    for (i = 0; i < pad_len; i++) begin
        all.push_back(8'(lfsr_bits(8)));
    end

    n = all.size();
    case (kind)
        KIND_TRUNC:     n = HDR_BYTES + cut;
        KIND_HDR_EARLY: n = 1 + lfsr_bits(5) % (HDR_BYTES - 1);
        default:        n = all.size();
    endcase
    for (i = 0; i < n; i++) begin
        frame_q.push_back({i == n - 1, all[i]});
    end
    bytes_total = bytes_total + n;

    if (kind <= KIND_TRUNC) begin
        exp_hdr_q.push_back(f);
    end
    case (kind)
        KIND_HDR_EARLY: exp_err[0]++;
        KIND_TRUNC:     exp_err[1]++;
        KIND_BAD_HDR:   exp_err[2]++;
        KIND_BAD_CSUM:  exp_err[3]++;
        default: ;
    endcase
endtask

`endif

// File: tests/tb_ip_rx.sv
// IPv4 receive testbench
// random frames from an LFSR checked against a reference model, with
// gaps on the input stream and back-pressure on both outputs
`timescale 1ns/1ps
`default_nettype none

module tb_ip_rx;
    import ip_rx_pkg::*;

    localparam logic [31:0] SEED            = 32'hbf5f617a;
    localparam int          CLK_HALF        = 2;
    localparam int          FRAMES_PER_TEST = 16;
    localparam int          TIMEOUT_FACTOR  = 8;
    localparam int          TIMEOUT_MARGIN  = 1000;

    logic        clk;
    logic        rst_n;
    byte_t       s_tdata;
    logic        s_tvalid;
    logic        s_tready;
    logic        s_tlast;
    logic        s_tuser;
    logic        m_hdr_valid;
    logic        m_hdr_ready;
    logic [15:0] m_ip_length;
    logic [7:0]  m_ip_ttl;
    logic [7:0]  m_ip_protocol;
    logic [15:0] m_ip_checksum;
    logic [31:0] m_ip_source_ip;
    logic [31:0] m_ip_dest_ip;
    byte_t       m_tdata;
    logic        m_tvalid;
    logic        m_tready;
    logic        m_tlast;
    logic        m_tuser;
    logic        err_header_early;
    logic        err_payload_early;
    logic        err_bad_header;
    logic        err_bad_checksum;

    logic [31:0] lfsr_q;
    int          cycle_cnt;
    int          error_count;
    int          tests_passed;
    int          tests_failed;
    int          err_seen[4];
    string       err_names[4] = '{"err_header_early", "err_payload_early",
                                  "err_bad_header", "err_bad_checksum"};

    ip_rx_top uut (
        .clk               (clk),
        .rst_n             (rst_n),
        .s_tdata           (s_tdata),
        .s_tvalid          (s_tvalid),
        .s_tready          (s_tready),
        .s_tlast           (s_tlast),
        .s_tuser           (s_tuser),
        .m_hdr_valid       (m_hdr_valid),
        .m_hdr_ready       (m_hdr_ready),
        .m_ip_length       (m_ip_length),
        .m_ip_ttl          (m_ip_ttl),
        .m_ip_protocol     (m_ip_protocol),
        .m_ip_checksum     (m_ip_checksum),
        .m_ip_source_ip    (m_ip_source_ip),
        .m_ip_dest_ip      (m_ip_dest_ip),
        .m_tdata           (m_tdata),
        .m_tvalid          (m_tvalid),
        .m_tready          (m_tready),
        .m_tlast           (m_tlast),
        .m_tuser           (m_tuser),
        .err_header_early  (err_header_early),
        .err_payload_early (err_payload_early),
        .err_bad_header    (err_bad_header),
        .err_bad_checksum  (err_bad_checksum)
    );

    // galois LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        int          k;
        v = 32'd0;
        for (k = 0; k < n; k++) begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    `include "ip_frame_model.svh"

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > TIMEOUT_FACTOR * bytes_total + TIMEOUT_MARGIN) begin
            $display("run stopped at cycle %0d, the DUT stopped making progress", cycle_cnt);
            $display("tests failed");
            $finish;
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("FAILED %0t %s expected %h actual %h", $time, name, exp, act);
        error_count++;
    endtask

    always @(posedge clk) begin : hdr_monitor
        ip_hdr_t e;
        if (rst_n && m_hdr_valid && m_hdr_ready) begin
            if (exp_hdr_q.size() == 0) begin
                $display("unexpected header beat at %0t", $time);
                error_count++;
            end else begin
                e = exp_hdr_q.pop_front();
                if (m_ip_length !== e.length) begin
                    report_mismatch("m_ip_length", e.length, m_ip_length);
                end
                if (m_ip_ttl !== e.ttl) begin
                    report_mismatch("m_ip_ttl", e.ttl, m_ip_ttl);
                end
                if (m_ip_protocol !== e.protocol) begin
                    report_mismatch("m_ip_protocol", e.protocol, m_ip_protocol);
                end
                if (m_ip_checksum !== e.checksum) begin
                    report_mismatch("m_ip_checksum", e.checksum, m_ip_checksum);
                end
                if (m_ip_source_ip !== e.source_ip) begin
                    report_mismatch("m_ip_source_ip", e.source_ip, m_ip_source_ip);
                end
                if (m_ip_dest_ip !== e.dest_ip) begin
                    report_mismatch("m_ip_dest_ip", e.dest_ip, m_ip_dest_ip);
                end
            end
        end
    end

    always @(posedge clk) begin : out_monitor
        logic [9:0] e;
        if (rst_n && m_tvalid && m_tready) begin
            if (exp_out_q.size() == 0) begin
                $display("unexpected output byte %h at %0t", m_tdata, $time);
                error_count++;
            end else begin
                e = exp_out_q.pop_front();
                if (m_tdata !== e[7:0]) begin
                    report_mismatch("m_tdata", e[7:0], m_tdata);
                end
                if (m_tlast !== e[9]) begin
                    report_mismatch("m_tlast", e[9], m_tlast);
                end
                if (m_tuser !== e[8]) begin
                    report_mismatch("m_tuser", e[8], m_tuser);
                end
            end
        end
    end

    // pulses are one cycle, so high cycles count the pulses
    always @(posedge clk) begin
        err_seen[0] += err_header_early;
        err_seen[1] += err_payload_early;
        err_seen[2] += err_bad_header;
        err_seen[3] += err_bad_checksum;
    end

    task automatic drive_ready();
        m_tready    = (lfsr_bits(2) != 32'd0);
        m_hdr_ready = (lfsr_bits(2) != 32'd0);
    endtask

    task automatic send_stream();
        while (frame_q.size() > 0) begin
            s_tdata  = frame_q[0][7:0];
            s_tlast  = frame_q[0][8];
            s_tvalid = (lfsr_bits(2) != 32'd0);
            drive_ready();
            @(posedge clk);
            if (s_tvalid && s_tready) begin
                void'(frame_q.pop_front());
            end
            #1;
        end
        s_tvalid = 1'b0;
        s_tlast  = 1'b0;
    endtask

    // wait for every expected beat, then idle a while for stray beats and pulses
    task automatic drain_outputs();
        int quiet;
        quiet = 0;
        while (exp_hdr_q.size() > 0 || exp_out_q.size() > 0 || quiet < 8) begin
            drive_ready();
            @(posedge clk);
            #1;
            if (exp_hdr_q.size() == 0 && exp_out_q.size() == 0) begin
                quiet++;
            end
        end
    endtask

    task automatic run_test(input int kind, input string name);
        int errors_before;
        int i;
        int k;
        errors_before = error_count;
        for (k = 0; k < 4; k++) begin
            exp_err[k]  = 0;
            err_seen[k] = 0;
        end
        for (i = 0; i < FRAMES_PER_TEST; i++) begin
            build_frame(kind);
            // a broken frame is followed by a clean one to show recovery
            if (kind >= KIND_BAD_CSUM) begin
                build_frame(lfsr_bits(1) != 0 ? KIND_PADDED : KIND_GOOD);
            end
        end
        send_stream();
        drain_outputs();
        for (k = 0; k < 4; k++) begin
            if (err_seen[k] != exp_err[k]) begin
                $display("FAILED %0t %s expected %0d pulses actual %0d",
                         $time, err_names[k], exp_err[k], err_seen[k]);
                error_count++;
            end
        end
        if (error_count == errors_before) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, error_count - errors_before);
        end
    endtask

    initial begin
        lfsr_q       = SEED;
        rst_n        = 1'b0;
        s_tdata      = 8'h00;
        s_tvalid     = 1'b0;
        s_tlast      = 1'b0;
        s_tuser      = 1'b0;
        m_hdr_ready  = 1'b0;
        m_tready     = 1'b0;
        cycle_cnt    = 0;
        error_count  = 0;
        tests_passed = 0;
        tests_failed = 0;
        bytes_total  = 0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        run_test(KIND_GOOD, "good frames");
        run_test(KIND_PADDED, "padded frames");
        run_test(KIND_TRUNC, "truncated payload");
        run_test(KIND_BAD_CSUM, "bad checksum");
        run_test(KIND_BAD_HDR, "bad version or ihl");
        run_test(KIND_HDR_EARLY, "header early termination");

        $display("%0d tests passing, %0d tests failing", tests_passed, tests_failed);
        if (tests_failed == 0 && error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+tests
verilog/ip_rx_pkg.sv
verilog/ip_stream_if.sv
verilog/ip_hdr_if.sv
verilog/ip_hdr_parser.sv
verilog/ip_frame_ctrl.sv
verilog/ip_payload_skid.sv
verilog/ip_rx_top.sv
tests/tb_ip_rx.sv
